//--- common/sap1_isa_pkg.sv
package sap1_isa_pkg;

    // Machine word types
    typedef logic [7:0] data_word_t;
    typedef logic [3:0] addr_t;
    typedef logic [3:0] nibble_t;

    localparam int MEM_DEPTH = 16;

    // Upper nibble of an instruction word
    typedef enum logic [3:0] {
        LDA = 4'h0,
        ADD = 4'h1,
        SUB = 4'h2,
        SNG = 4'h3,
        OUT = 4'hE,
        HLT = 4'hF
    } opcode_e;

    typedef enum logic [2:0] {T0, T1, T2, T3, T4, T5} tstate_e;

    // Control word bit positions
    localparam int CTRL_BITS      = 13;
    localparam int CTRL_PC_INC    = 12;
    localparam int CTRL_PC_EN     = 11;
    localparam int CTRL_MAR_LOAD  = 10;
    localparam int CTRL_MEM_EN    = 9;
    localparam int CTRL_IR_LOAD   = 8;
    localparam int CTRL_IR_EN     = 7;
    localparam int CTRL_A_LOAD    = 6;
    localparam int CTRL_A_EN      = 5;
    localparam int CTRL_B_LOAD    = 4;
    localparam int CTRL_ADDER_SUB = 3;
    localparam int CTRL_ACC_LOAD  = 2;
    localparam int CTRL_HLT       = 1;
    localparam int CTRL_SNG_EN    = 0;

    typedef logic [CTRL_BITS-1:0] ctrl_word_t;

endpackage

//--- common/sap1_board_pkg.sv
package sap1_board_pkg;

    // Operation chosen from the switches
    typedef enum logic [1:0] {NONE, ADD, SUB, SONG} op_select_e;

    typedef enum logic [2:0] {
        SELECT_OP,
        ENTER_A,
        ENTER_B,
        ENTER_SONG,
        READY
    } entry_state_e;

    // A, B, acc, 4'b0 + PC, sng_en, operand, T-state, MSB first
    localparam int FRAME_BITS = 40;

    typedef logic [FRAME_BITS-1:0] frame_t;

endpackage

//--- console/button_debouncer.sv
`timescale 1ns/1ps

module button_debouncer #(
    parameter int DEBOUNCE_CYCLES = 1_000_000
) (
    input  logic clk,
    input  logic reset,
    input  logic btn,
    output logic confirm
);

    localparam int CNT_W = $clog2(DEBOUNCE_CYCLES + 1);

    logic             btn_sync;
    logic             btn_prev;
    logic             armed;     // Cleared by a press, set again by a stable release
    logic [CNT_W-1:0] stable_cnt;
    logic             settled;

    // Counter is one short of the limit and the level did not move
    assign settled = (btn_sync == btn_prev) && (stable_cnt == CNT_W'(DEBOUNCE_CYCLES - 1));

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            btn_sync   <= 1'b0;
            btn_prev   <= 1'b0;
            armed      <= 1'b1;
            stable_cnt <= '0;
            confirm    <= 1'b0;
        end else begin
            btn_sync <= btn;
            btn_prev <= btn_sync;
            confirm  <= 1'b0;
            if (btn_sync != btn_prev) begin
                stable_cnt <= '0;   // Any bounce restarts the wait
            end else if (stable_cnt != CNT_W'(DEBOUNCE_CYCLES)) begin
                stable_cnt <= stable_cnt + 1'b1;
            end
            if (settled && btn_prev && armed) begin
                confirm <= 1'b1;
                armed   <= 1'b0;
            end else if (settled && !btn_prev) begin
                armed <= 1'b1;
            end
        end
    end

endmodule

//--- console/program_entry.sv
`timescale 1ns/1ps

module program_entry (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    confirm,
    input  logic [2:0]              sw_op,
    input  sap1_isa_pkg::data_word_t sw_value,
    input  sap1_isa_pkg::addr_t     mem_addr,
    output logic                    program_ready,
    output sap1_isa_pkg::data_word_t mem_data
);

    sap1_board_pkg::entry_state_e state;
    sap1_board_pkg::op_select_e   op;
    sap1_isa_pkg::data_word_t     value_a;
    sap1_isa_pkg::data_word_t     mem   [sap1_isa_pkg::MEM_DEPTH];
    sap1_isa_pkg::data_word_t     image [sap1_isa_pkg::MEM_DEPTH];
    logic                         load_program;

    // Last operand confirmed, program image goes in on the same edge
    assign load_program = confirm && (state == sap1_board_pkg::ENTER_B ||
                                      state == sap1_board_pkg::ENTER_SONG);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state         <= sap1_board_pkg::SELECT_OP;
            op            <= sap1_board_pkg::NONE;
            program_ready <= 1'b0;
        end else if (confirm) begin
            case (state)
                sap1_board_pkg::SELECT_OP: begin
                    if (sw_op[2]) begin
                        op    <= sap1_board_pkg::ADD;
                        state <= sap1_board_pkg::ENTER_A;
                    end else if (sw_op[1]) begin
                        op    <= sap1_board_pkg::SUB;
                        state <= sap1_board_pkg::ENTER_A;
                    end else if (sw_op[0]) begin
                        op    <= sap1_board_pkg::SONG;
                        state <= sap1_board_pkg::ENTER_SONG;
                    end
                end
                sap1_board_pkg::ENTER_A:    state <= sap1_board_pkg::ENTER_B;
                sap1_board_pkg::ENTER_B,
                sap1_board_pkg::ENTER_SONG: begin
                    state         <= sap1_board_pkg::READY;
                    program_ready <= 1'b1;
                end
                default: ;   // READY holds until reset
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (confirm && state == sap1_board_pkg::ENTER_A) begin
            value_a <= sw_value;
        end
    end

    // Fixed program for the selected operation
    always_comb begin
        for (int i = 0; i < sap1_isa_pkg::MEM_DEPTH; i++) begin
            image[i] = '0;
        end
        if (op == sap1_board_pkg::SONG) begin
            image[0] = {sap1_isa_pkg::SNG, sw_value[3:0]};
            image[1] = {sap1_isa_pkg::HLT, 4'h0};
        end else begin
            image[0]  = {sap1_isa_pkg::LDA, 4'd15};
            image[1]  = (op == sap1_board_pkg::SUB) ? {sap1_isa_pkg::SUB, 4'd14}
                                                    : {sap1_isa_pkg::ADD, 4'd14};
            image[2]  = {sap1_isa_pkg::OUT, 4'h0};
            image[3]  = {sap1_isa_pkg::SNG, 4'h0}; // Beep when done
            image[4]  = {sap1_isa_pkg::HLT, 4'h0};
            image[14] = sw_value;                  // B
            image[15] = value_a;
        end
    end

    always_ff @(posedge clk) begin
        if (load_program) begin
            for (int i = 0; i < sap1_isa_pkg::MEM_DEPTH; i++) begin
                mem[i] <= image[i];
            end
        end
    end

    assign mem_data = mem[mem_addr];

endmodule

//--- cpu/sap1_sequencer.sv
`timescale 1ns/1ps

module sap1_sequencer #(
    parameter int STEP_DIV = 100_000_000
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   program_ready,
    input  sap1_isa_pkg::opcode_e  opcode,
    output logic                   step,
    output sap1_isa_pkg::tstate_e  tstate,
    output sap1_isa_pkg::ctrl_word_t ctrl,
    output logic                   halted
);

    localparam int DIV_W = (STEP_DIV > 1) ? $clog2(STEP_DIV) : 1;

    logic [DIV_W-1:0] div_cnt;
    logic             running;

    assign running = program_ready && !halted;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            div_cnt <= '0;
            step    <= 1'b0;
        end else begin
            step <= 1'b0;
            if (running) begin
                if (div_cnt == DIV_W'(STEP_DIV - 1)) begin
                    div_cnt <= '0;
                    step    <= 1'b1;
                end else begin
                    div_cnt <= div_cnt + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            tstate <= sap1_isa_pkg::T0;
            halted <= 1'b0;
        end else if (step) begin
            if (ctrl[sap1_isa_pkg::CTRL_HLT]) begin
                halted <= 1'b1;   // T-state freezes at T3
            end else if (tstate == sap1_isa_pkg::T5) begin
                tstate <= sap1_isa_pkg::T0;
            end else begin
                tstate <= sap1_isa_pkg::tstate_e'(tstate + 3'd1);
            end
        end
    end

    always_comb begin
        ctrl = '0;
        case (tstate)
            sap1_isa_pkg::T0: begin
                ctrl[sap1_isa_pkg::CTRL_PC_EN]    = 1'b1;
                ctrl[sap1_isa_pkg::CTRL_MAR_LOAD] = 1'b1;
            end
            sap1_isa_pkg::T1: ctrl[sap1_isa_pkg::CTRL_PC_INC] = 1'b1;
            sap1_isa_pkg::T2: begin
                ctrl[sap1_isa_pkg::CTRL_MEM_EN]  = 1'b1;
                ctrl[sap1_isa_pkg::CTRL_IR_LOAD] = 1'b1;
            end
            sap1_isa_pkg::T3: begin
                case (opcode)
                    sap1_isa_pkg::LDA, sap1_isa_pkg::ADD, sap1_isa_pkg::SUB: begin
                        ctrl[sap1_isa_pkg::CTRL_IR_EN]    = 1'b1; // Operand address to MAR
                        ctrl[sap1_isa_pkg::CTRL_MAR_LOAD] = 1'b1;
                    end
                    sap1_isa_pkg::OUT: ctrl[sap1_isa_pkg::CTRL_A_EN]   = 1'b1;
                    sap1_isa_pkg::SNG: ctrl[sap1_isa_pkg::CTRL_SNG_EN] = 1'b1;
                    sap1_isa_pkg::HLT: ctrl[sap1_isa_pkg::CTRL_HLT]    = 1'b1;
                    default: ;
                endcase
            end
            sap1_isa_pkg::T4: begin
                if (opcode == sap1_isa_pkg::LDA) begin
                    ctrl[sap1_isa_pkg::CTRL_MEM_EN] = 1'b1;
                    ctrl[sap1_isa_pkg::CTRL_A_LOAD] = 1'b1;
                end else if (opcode == sap1_isa_pkg::ADD || opcode == sap1_isa_pkg::SUB) begin
                    ctrl[sap1_isa_pkg::CTRL_MEM_EN] = 1'b1;
                    ctrl[sap1_isa_pkg::CTRL_B_LOAD] = 1'b1;
                end
            end
            sap1_isa_pkg::T5: begin
                if (opcode == sap1_isa_pkg::ADD || opcode == sap1_isa_pkg::SUB) begin
                    ctrl[sap1_isa_pkg::CTRL_ACC_LOAD]  = 1'b1;
                    ctrl[sap1_isa_pkg::CTRL_ADDER_SUB] = (opcode == sap1_isa_pkg::SUB);
                end
            end
            default: ;
        endcase
    end

endmodule

//--- cpu/sap1_datapath.sv
`timescale 1ns/1ps

module sap1_datapath (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     step,
    input  sap1_isa_pkg::ctrl_word_t ctrl,
    output sap1_isa_pkg::addr_t      mem_addr,
    output sap1_isa_pkg::opcode_e    opcode,
    output sap1_isa_pkg::nibble_t    operand,
    output sap1_isa_pkg::data_word_t reg_a,
    output sap1_isa_pkg::data_word_t reg_b,
    output sap1_isa_pkg::data_word_t acc,
    output sap1_isa_pkg::addr_t      pc,
    output sap1_isa_pkg::data_word_t result,
    output logic                     tone_start,
    output sap1_isa_pkg::nibble_t    tone_number,
    input  sap1_isa_pkg::data_word_t mem_data
);

    sap1_isa_pkg::data_word_t ir;
    sap1_isa_pkg::data_word_t bus;
    sap1_isa_pkg::data_word_t alu_out;

    assign opcode  = sap1_isa_pkg::opcode_e'(ir[7:4]);
    assign operand = ir[3:0];
    assign alu_out = ctrl[sap1_isa_pkg::CTRL_ADDER_SUB] ? reg_a - reg_b : reg_a + reg_b;

    // One source at a time, accumulator when nothing else drives
    always_comb begin
        if (ctrl[sap1_isa_pkg::CTRL_PC_EN]) begin
            bus = {4'b0, pc};
        end else if (ctrl[sap1_isa_pkg::CTRL_MEM_EN]) begin
            bus = mem_data;
        end else if (ctrl[sap1_isa_pkg::CTRL_IR_EN]) begin
            bus = {4'b0, operand};
        end else if (ctrl[sap1_isa_pkg::CTRL_A_EN]) begin
            bus = reg_a;
        end else begin
            bus = acc;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc          <= '0;
            mem_addr    <= '0;
            ir          <= '0;
            reg_a       <= '0;
            reg_b       <= '0;
            acc         <= '0;
            result      <= '0;
            tone_start  <= 1'b0;
            tone_number <= '0;
        end else begin
            tone_start <= step && ctrl[sap1_isa_pkg::CTRL_SNG_EN];
            if (step) begin
                if (ctrl[sap1_isa_pkg::CTRL_PC_INC])   pc       <= pc + 1'b1;
                if (ctrl[sap1_isa_pkg::CTRL_MAR_LOAD]) mem_addr <= bus[3:0];
                if (ctrl[sap1_isa_pkg::CTRL_IR_LOAD])  ir       <= bus;
                if (ctrl[sap1_isa_pkg::CTRL_A_LOAD])   reg_a    <= bus;
                if (ctrl[sap1_isa_pkg::CTRL_B_LOAD])   reg_b    <= bus;
                if (ctrl[sap1_isa_pkg::CTRL_ACC_LOAD]) acc      <= alu_out; // Wraps mod 256
                // OUT shows the last ALU result held in the accumulator
                if (ctrl[sap1_isa_pkg::CTRL_A_EN])     result   <= acc;
                if (ctrl[sap1_isa_pkg::CTRL_SNG_EN])   tone_number <= operand;
            end
        end
    end

endmodule

//--- rtl/spi_telemetry.sv
`timescale 1ns/1ps

module spi_telemetry #(
    parameter int SPI_DIV = 200
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     step,
    input  logic                     halted,
    input  sap1_isa_pkg::tstate_e    tstate,
    input  logic                     sng_en,
    input  sap1_isa_pkg::data_word_t reg_a,
    input  sap1_isa_pkg::data_word_t reg_b,
    input  sap1_isa_pkg::data_word_t acc,
    input  sap1_isa_pkg::addr_t      pc,
    input  sap1_isa_pkg::nibble_t    operand,
    output logic                     sclk,
    output logic                     mosi,
    output logic                     cs_n
);

    localparam int HALF_W  = (SPI_DIV > 1) ? $clog2(SPI_DIV) : 1;
    localparam int EDGES   = 2 * sap1_board_pkg::FRAME_BITS;
    localparam int EDGE_W  = $clog2(EDGES + 1);

    sap1_board_pkg::frame_t frame;
    sap1_board_pkg::frame_t shreg;   // Current bit at the MSB
    logic                   busy;
    logic [HALF_W-1:0]      half_cnt;
    logic [EDGE_W-1:0]      edge_cnt;

    assign frame = {reg_a, reg_b, acc, 4'b0, pc, sng_en, operand, tstate};

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            busy     <= 1'b0;
            half_cnt <= '0;
            edge_cnt <= '0;
            sclk     <= 1'b0;
            mosi     <= 1'b0;
            cs_n     <= 1'b1;
        end else if (!busy) begin
            if (step && !halted) begin   // Steps seen while busy are dropped
                busy     <= 1'b1;
                cs_n     <= 1'b0;
                mosi     <= frame[sap1_board_pkg::FRAME_BITS-1];
                half_cnt <= '0;
                edge_cnt <= '0;
            end
        end else if (half_cnt != HALF_W'(SPI_DIV - 1)) begin
            half_cnt <= half_cnt + 1'b1;
        end else begin
            half_cnt <= '0;
            if (edge_cnt == EDGE_W'(EDGES)) begin
                busy <= 1'b0;   // Half period after the last falling edge
                cs_n <= 1'b1;
                mosi <= 1'b0;
            end else begin
                sclk     <= ~sclk;
                edge_cnt <= edge_cnt + 1'b1;
                if (sclk) begin
                    mosi <= shreg[sap1_board_pkg::FRAME_BITS-2]; // Falling edge, next bit
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!busy) begin
            shreg <= frame;
        end else if (half_cnt == HALF_W'(SPI_DIV - 1) && sclk) begin
            shreg <= {shreg[sap1_board_pkg::FRAME_BITS-2:0], 1'b0};
        end
    end

endmodule

//--- rtl/sap1_system.sv
`timescale 1ns/1ps

module sap1_system #(
    parameter int DEBOUNCE_CYCLES = 1_000_000,
    parameter int STEP_DIV        = 100_000_000,
    parameter int SPI_DIV         = 200
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     confirm_btn,
    input  logic [2:0]               sw_op,       // Add, sub, song
    input  sap1_isa_pkg::data_word_t sw_value,
    output sap1_isa_pkg::data_word_t result,
    output logic                     halted,
    output logic                     tone_start,
    output sap1_isa_pkg::nibble_t    tone_number,
    output logic                     sclk,
    output logic                     mosi,
    output logic                     cs_n
);

    logic                     confirm;
    logic                     program_ready;
    logic                     step;
    sap1_isa_pkg::addr_t      mem_addr;
    sap1_isa_pkg::data_word_t mem_data;
    sap1_isa_pkg::opcode_e    opcode;
    sap1_isa_pkg::tstate_e    tstate;
    sap1_isa_pkg::ctrl_word_t ctrl;
    sap1_isa_pkg::nibble_t    operand;
    sap1_isa_pkg::data_word_t reg_a;
    sap1_isa_pkg::data_word_t reg_b;
    sap1_isa_pkg::data_word_t acc;
    sap1_isa_pkg::addr_t      pc;

    button_debouncer #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) button_debouncer_i (
        .clk(clk), .reset(reset), .btn(confirm_btn), .confirm(confirm)
    );

    program_entry program_entry_i (
        .clk(clk), .reset(reset), .confirm(confirm), .sw_op(sw_op), .sw_value(sw_value),
        .mem_addr(mem_addr), .program_ready(program_ready), .mem_data(mem_data)
    );

    sap1_sequencer #(.STEP_DIV(STEP_DIV)) sap1_sequencer_i (
        .clk(clk), .reset(reset), .program_ready(program_ready), .opcode(opcode),
        .step(step), .tstate(tstate), .ctrl(ctrl), .halted(halted)
    );

    sap1_datapath sap1_datapath_i (
        .clk(clk), .reset(reset), .step(step), .ctrl(ctrl), .mem_addr(mem_addr),
        .opcode(opcode), .operand(operand), .reg_a(reg_a), .reg_b(reg_b), .acc(acc),
        .pc(pc), .result(result), .tone_start(tone_start), .tone_number(tone_number),
        .mem_data(mem_data)
    );

    spi_telemetry #(.SPI_DIV(SPI_DIV)) spi_telemetry_i (
        .clk(clk), .reset(reset), .step(step), .halted(halted), .tstate(tstate),
        .sng_en(ctrl[sap1_isa_pkg::CTRL_SNG_EN]), .reg_a(reg_a), .reg_b(reg_b),
        .acc(acc), .pc(pc), .operand(operand), .sclk(sclk), .mosi(mosi), .cs_n(cs_n)
    );

endmodule

//--- dv/sap1_system_asserts.sv
`timescale 1ns/1ps

module sap1_system_asserts (
    input logic       clk,
    input logic       reset,
    input logic       cs_n,
    input logic       sclk,
    input logic       tone_start,
    input logic       halted,
    input logic [7:0] result
);

    int fail_count = 0;   // Read by the testbench for its totals

    // Mode 0 idle level outside a frame
    idle_clock_low: assert property (@(posedge clk) disable iff (reset) cs_n |-> !sclk)
        else begin
            $error("sclk high while cs_n is high");
            fail_count++;
        end

    tone_single_cycle: assert property (@(posedge clk) disable iff (reset)
        tone_start |=> !tone_start)
        else begin
            $error("tone_start held for more than one cycle");
            fail_count++;
        end

    halt_sticky: assert property (@(posedge clk) disable iff (reset) halted |=> halted)
        else begin
            $error("halted fell without a reset");
            fail_count++;
        end

    // Nothing executes after HLT
    result_frozen: assert property (@(posedge clk) disable iff (reset)
        halted |=> $stable(result))
        else begin
            $error("result changed while halted");
            fail_count++;
        end

endmodule

bind sap1_system sap1_system_asserts sap1_system_asserts_i (.*);

//--- dv/sap1_system_tb.sv
`timescale 1ns/1ps

module sap1_system_tb;

    localparam int DEBOUNCE_CYCLES = 8;
    localparam int STEP_DIV        = 4;
    localparam int SPI_DIV         = 2;
    localparam int PRESSES         = 12;   // Over all five tests
    localparam int TIMEOUT_CYCLES  = 4 * (PRESSES * 32 + 30 * STEP_DIV
                                     + 2 * 2 * sap1_board_pkg::FRAME_BITS * SPI_DIV + 100);

    logic       clk = 1'b0;
    logic       reset = 1'b1;
    logic       confirm_btn = 1'b0;
    logic [2:0] sw_op = 3'b000;
    logic [7:0] sw_value = 8'h00;
    logic [7:0] result;
    logic       halted;
    logic       tone_start;
    logic [3:0] tone_number;
    logic       sclk;
    logic       mosi;
    logic       cs_n;

    integer      seed = 32'haef31721;
    int          error_count = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          cycle_count = 0;
    int          idle_faults, tone_count, frame_starts, late_starts, frame_len;
    logic [3:0]  last_tone;
    logic [39:0] frame_shift;
    logic [39:0] frames[$];
    int          frame_lens[$];
    logic        prev_cs_n = 1'b1;
    logic        prev_sclk = 1'b0;
    logic        prev_halted = 1'b0;

    sap1_system #(
        .DEBOUNCE_CYCLES(DEBOUNCE_CYCLES),
        .STEP_DIV(STEP_DIV),
        .SPI_DIV(SPI_DIV)
    ) sap1_system_i (
        .clk(clk), .reset(reset), .confirm_btn(confirm_btn), .sw_op(sw_op),
        .sw_value(sw_value), .result(result), .halted(halted), .tone_start(tone_start),
        .tone_number(tone_number), .sclk(sclk), .mosi(mosi), .cs_n(cs_n)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > TIMEOUT_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    // Output monitor, away from the active clock edge
    always @(negedge clk) begin
        if (halted || tone_start || mosi || !cs_n) idle_faults++;
        if (tone_start) begin
            tone_count++;
            last_tone = tone_number;
        end
        if (prev_cs_n && !cs_n) begin
            frame_starts++;
            if (prev_halted) late_starts++;
            frame_len = 0;
        end
        if (!cs_n && sclk && !prev_sclk) begin   // Rising SCLK
            frame_shift = {frame_shift[38:0], mosi};
            frame_len++;
        end
        if (!prev_cs_n && cs_n) begin
            frames.push_back(frame_shift);
            frame_lens.push_back(frame_len);
        end
        prev_cs_n   = cs_n;
        prev_sclk   = sclk;
        prev_halted = halted;
    end

    function automatic int total_errors();
        return error_count + sap1_system_i.sap1_system_asserts_i.fail_count;
    endfunction

    task automatic apply_reset();
        @(posedge clk);
        #1 reset = 1'b1;
        confirm_btn = 1'b0;
        sw_op = 3'b000;
        repeat (8) @(posedge clk);
        #1 reset = 1'b0;
        idle_faults = 0;   // Monitor state of the previous test
        tone_count = 0;
        frame_starts = 0;
        late_starts = 0;
        frames.delete();
        frame_lens.delete();
    endtask

    task automatic press_button(input logic [2:0] op, input logic [7:0] value);
        @(posedge clk);
        #1 sw_op = op;
        sw_value = value;
        confirm_btn = 1'b1;
        repeat (16) @(posedge clk);
        #1 confirm_btn = 1'b0;
        repeat (16) @(posedge clk);
    endtask

    task automatic wait_for_halt();
        while (!halted) @(posedge clk);
        @(posedge clk);
        #1;
    endtask

    task automatic check_value(input string name, input int expected, input int actual);
        assert (expected == actual) else begin
            error_count++;
            $display("ERROR %s: expected %0d, actual %0d", name, expected, actual);
        end
    endtask

    task automatic check_true(input string name, input logic cond, input string what);
        assert (cond) else begin
            error_count++;
            $display("%s: %s", name, what);
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests_run++;
        if (total_errors() == errors_before) begin
            $display("test %s: passed", name);
        end else begin
            tests_failed++;
            $display("test %s: failed", name);
        end
    endtask

    initial begin
        int          errors_before;
        logic [31:0] rnd;
        logic [7:0]  a;
        logic [7:0]  b;
        logic [3:0]  n;

        apply_reset();
        errors_before = total_errors();
        press_button(3'b000, 8'h00);   // No operation selected
        repeat (200) @(posedge clk);
        check_true("idle", idle_faults == 0, "outputs left their idle levels");
        check_true("idle", frame_starts == 0, "telemetry frame started with no program");
        report_test("idle", errors_before);

        apply_reset();
        errors_before = total_errors();
        rnd = $random(seed);
        a = rnd[7:0];
        rnd = $random(seed);
        b = rnd[7:0];
        press_button(3'b100, 8'h00);
        press_button(3'b000, a);
        press_button(3'b000, b);
        wait_for_halt();
        check_value("add result", 8'(a + b), result);
        check_value("add tone count", 1, tone_count);
        check_value("add tone number", 0, last_tone);
        report_test("add", errors_before);

        apply_reset();
        errors_before = total_errors();
        rnd = $random(seed);
        a = rnd[7:0];
        rnd = $random(seed);
        b = rnd[7:0];
        press_button(3'b010, 8'h00);
        press_button(3'b000, a);
        press_button(3'b000, b);
        wait_for_halt();
        check_value("sub result", 8'(a - b), result);
        report_test("sub", errors_before);

        apply_reset();
        errors_before = total_errors();
        rnd = $random(seed);
        n = rnd[3:0];
        press_button(3'b001, 8'h00);
        press_button(3'b000, {4'h0, n});
        wait_for_halt();
        check_value("song tone count", 1, tone_count);
        check_value("song tone number", n, last_tone);
        check_value("song result", 0, result);
        report_test("song", errors_before);

        apply_reset();
        errors_before = total_errors();
        rnd = $random(seed);
        a = rnd[7:0];
        rnd = $random(seed);
        b = rnd[7:0];
        press_button(3'b100, 8'h00);
        press_button(3'b000, a);
        press_button(3'b000, b);
        wait_for_halt();
        while (!cs_n) @(posedge clk);   // Let the last frame drain
        repeat (40) @(posedge clk);
        check_true("telemetry", frames.size() > 0, "no telemetry frame was captured");
        check_value("telemetry late frames", 0, late_starts);
        foreach (frames[i]) begin
            check_value("telemetry frame length", 40, frame_lens[i]);
            check_value("telemetry zero bits", 0, frames[i][15:12]);
            check_true("telemetry", frames[i][2:0] <= 3'd5, "T-state field above T5");
            check_true("telemetry", frames[i][39:32] == 8'h00 || frames[i][39:32] == a,
                       "A field holds neither 0 nor a");
            check_true("telemetry", frames[i][31:24] == 8'h00 || frames[i][31:24] == b,
                       "B field holds neither 0 nor b");
            check_true("telemetry", frames[i][23:16] == 8'h00 ||
                       frames[i][23:16] == 8'(a + b), "accumulator field holds neither 0 nor a+b");
        end
        report_test("telemetry", errors_before);

        $display("Tests run: %0d, failed: %0d, errors: %0d",
                 tests_run, tests_failed, total_errors());
        if (total_errors() == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

//--- list.f
common/sap1_isa_pkg.sv
common/sap1_board_pkg.sv
console/button_debouncer.sv
console/program_entry.sv
cpu/sap1_sequencer.sv
cpu/sap1_datapath.sv
rtl/spi_telemetry.sv
rtl/sap1_system.sv
dv/sap1_system_asserts.sv
dv/sap1_system_tb.sv

//--- Bender.yml
package:
  name: sap1_system

sources:
  - common/sap1_isa_pkg.sv
  - common/sap1_board_pkg.sv
  - console/button_debouncer.sv
  - console/program_entry.sv
  - cpu/sap1_sequencer.sv
  - cpu/sap1_datapath.sv
  - rtl/spi_telemetry.sv
  - rtl/sap1_system.sv
  - target: simulation
    files:
      - dv/sap1_system_asserts.sv
      - dv/sap1_system_tb.sv
